/* Makefile */
# Verilator build for the bus peripheral testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -Wno-fatal --timescale $(TIMESCALE)
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+testbench
source/soc_bus_pkg.sv
source/bus_front.sv
source/ram_bank.sv
source/plic_regs.sv
source/machine_timer.sv
source/bus_response.sv
source/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* source/bus_front.sv */
module bus_front (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  soc_bus_pkg::bus_req_t bus_req,
    input  logic                  complete,
    output logic                  start,
    output soc_bus_pkg::bus_req_t cur_req,
    output soc_bus_pkg::target_t  target
);

    soc_bus_pkg::front_state_t state_q;
    logic                      captured_q;  // request taken last cycle
    soc_bus_pkg::target_t      target_d;

    // address map decode on the held request
    always_comb begin
        if (cur_req.addr >= soc_bus_pkg::RAM_BASE &&
            cur_req.addr < soc_bus_pkg::RAM_BASE + soc_bus_pkg::RAM_BYTES) begin
            target_d = soc_bus_pkg::TGT_RAM;
        end else if (cur_req.addr == soc_bus_pkg::MTIME_ADDR ||
                     cur_req.addr == soc_bus_pkg::MTIMECMP_ADDR) begin
            target_d = soc_bus_pkg::TGT_TIMER;
        end else if (cur_req.addr >= soc_bus_pkg::PLIC_BASE &&
                     cur_req.addr < soc_bus_pkg::PLIC_BASE + soc_bus_pkg::PLIC_SPAN) begin
            target_d = soc_bus_pkg::TGT_PLIC;
        end else begin
            target_d = soc_bus_pkg::TGT_NONE;  // unmapped
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state_q    <= soc_bus_pkg::FRONT_IDLE;
            captured_q <= 1'b0;
            start      <= 1'b0;
            target     <= soc_bus_pkg::TGT_NONE;
        end else begin
            captured_q <= 1'b0;
            start      <= captured_q;   // one pulse per request
            if (captured_q) begin
                target <= target_d;
            end
            case (state_q)
                soc_bus_pkg::FRONT_IDLE: begin
                    if (req_valid) begin
                        state_q    <= soc_bus_pkg::FRONT_BUSY;
                        captured_q <= 1'b1;
                    end
                end
                soc_bus_pkg::FRONT_BUSY: begin
                    if (complete) state_q <= soc_bus_pkg::FRONT_IDLE;
                end
                default: state_q <= soc_bus_pkg::FRONT_IDLE;
            endcase
        end
    end

    // request held for the whole transaction
    always_ff @(posedge CLOCK_50) begin
        if (state_q == soc_bus_pkg::FRONT_IDLE && req_valid) begin
            cur_req <= bus_req;
        end
    end

endmodule

/* source/bus_response.sv */
module bus_response (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  start,
    input  soc_bus_pkg::target_t  target,
    input  soc_bus_pkg::tgt_rsp_t ram_rsp,
    input  soc_bus_pkg::tgt_rsp_t plic_rsp,
    input  soc_bus_pkg::tgt_rsp_t timer_rsp,
    output logic                  complete,
    output logic                  done,
    output soc_bus_pkg::data_t    rdata
);

    logic               none_ack_q;   // stands in for a missing target
    logic               any_ack;
    soc_bus_pkg::data_t sel_data;

    assign any_ack = ram_rsp.ack | plic_rsp.ack | timer_rsp.ack | none_ack_q;

    // only one target acks at a time
    always_comb begin
        if (ram_rsp.ack) begin
            sel_data = ram_rsp.rdata;
        end else if (plic_rsp.ack) begin
            sel_data = plic_rsp.rdata;
        end else if (timer_rsp.ack) begin
            sel_data = timer_rsp.rdata;
        end else begin
            sel_data = '0;              // unmapped reads give zero
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_ack_q <= 1'b0;
            done       <= 1'b0;
            complete   <= 1'b0;
        end else begin
            none_ack_q <= start && (target == soc_bus_pkg::TGT_NONE);
            done       <= any_ack;
            complete   <= any_ack;  // frees the front end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (any_ack) rdata <= sel_data;
    end

endmodule

/* source/machine_timer.sv */
module machine_timer (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  start,
    input  soc_bus_pkg::target_t  target,
    input  soc_bus_pkg::bus_req_t cur_req,
    output soc_bus_pkg::tgt_rsp_t rsp,
    output logic                  mtip
);

    logic               sel;
    logic               ack_q;
    soc_bus_pkg::data_t mtime_q;
    soc_bus_pkg::data_t mtimecmp_q;
    soc_bus_pkg::data_t rdata_q;

    assign sel  = start && (target == soc_bus_pkg::TGT_TIMER);
    assign mtip = mtime_q >= mtimecmp_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime_q    <= '0;
            mtimecmp_q <= soc_bus_pkg::MTIMECMP_RESET;
            ack_q      <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;     // free running
            ack_q   <= sel;
            if (sel && cur_req.write && cur_req.addr == soc_bus_pkg::MTIMECMP_ADDR) begin
                mtimecmp_q <= cur_req.wdata;
            end
        end
    end

    // mtime writes are dropped
    always_ff @(posedge CLOCK_50) begin
        if (sel) begin
            rdata_q <= (cur_req.addr == soc_bus_pkg::MTIME_ADDR) ? mtime_q : mtimecmp_q;
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

/* source/plic_regs.sv */
module plic_regs (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  start,
    input  soc_bus_pkg::target_t  target,
    input  soc_bus_pkg::bus_req_t cur_req,
    input  soc_bus_pkg::irq_vec_t irq_src,
    output soc_bus_pkg::tgt_rsp_t rsp,
    output logic                  meip,
    output logic                  seip
);

    logic                            sel;
    logic                            prio_hit;
    logic                            prio_ok;
    logic                            pend_hit;
    logic [9:0]                      prio_idx;   // source id from address
    logic [soc_bus_pkg::NUM_CTX-1:0] en_hit;
    logic [soc_bus_pkg::NUM_CTX-1:0] th_hit;
    logic [soc_bus_pkg::NUM_CTX-1:0] cl_hit;
    logic                            ack_q;
    soc_bus_pkg::irq_vec_t           src_q;
    soc_bus_pkg::irq_vec_t           rise;
    soc_bus_pkg::irq_vec_t           pending_q;
    soc_bus_pkg::irq_vec_t           clear;
    soc_bus_pkg::irq_vec_t           enable_q [soc_bus_pkg::NUM_CTX];
    soc_bus_pkg::prio_t              prio_q [1:soc_bus_pkg::NUM_IRQ_SRC];
    soc_bus_pkg::prio_t              thresh_q [soc_bus_pkg::NUM_CTX];
    soc_bus_pkg::irq_id_t            claim_id [soc_bus_pkg::NUM_CTX];
    soc_bus_pkg::data_t              rd_val;
    soc_bus_pkg::data_t              rdata_q;

    assign sel      = start && (target == soc_bus_pkg::TGT_PLIC);
    assign rise     = irq_src & ~src_q;     // edge triggered sources
    assign prio_idx = cur_req.addr[11:2];
    assign prio_hit = cur_req.addr >= soc_bus_pkg::PLIC_BASE &&
                      cur_req.addr < soc_bus_pkg::PLIC_PENDING;
    assign prio_ok  = prio_idx >= 10'd1 && prio_idx <= soc_bus_pkg::NUM_IRQ_SRC;
    assign pend_hit = cur_req.addr == soc_bus_pkg::PLIC_PENDING;

    always_comb begin
        for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
            en_hit[c] = cur_req.addr == soc_bus_pkg::PLIC_ENABLE0
                        + soc_bus_pkg::PLIC_EN_STRIDE * soc_bus_pkg::addr_t'(c);
            th_hit[c] = cur_req.addr == soc_bus_pkg::PLIC_THRESH0
                        + soc_bus_pkg::PLIC_CTX_STRIDE * soc_bus_pkg::addr_t'(c);
            cl_hit[c] = cur_req.addr == soc_bus_pkg::PLIC_CLAIM0
                        + soc_bus_pkg::PLIC_CTX_STRIDE * soc_bus_pkg::addr_t'(c);
        end
    end

    // best candidate per context
    always_comb begin
        for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
            claim_id[c] = '0;
            for (int i = soc_bus_pkg::NUM_IRQ_SRC; i >= 1; i--) begin  // lowest id wins
                if (pending_q[i] && enable_q[c][i] && prio_q[i] > thresh_q[c]) begin
                    claim_id[c] = soc_bus_pkg::irq_id_t'(i);
                end
            end
        end
    end

    assign meip = claim_id[0] != '0;
    assign seip = claim_id[1] != '0;

    always_comb begin
        clear = '0;
        for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
            if (sel && !cur_req.write && cl_hit[c] && claim_id[c] != '0) begin
                clear[claim_id[c]] = 1'b1;  // claim read takes the source
            end
        end
    end

    always_comb begin
        rd_val = '0;
        if (prio_hit && prio_ok) begin
            rd_val = soc_bus_pkg::data_t'(prio_q[prio_idx[soc_bus_pkg::IRQ_ID_W-1:0]]);
        end
        if (pend_hit) rd_val = soc_bus_pkg::data_t'({pending_q, 1'b0});
        for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
            if (en_hit[c]) rd_val = soc_bus_pkg::data_t'({enable_q[c], 1'b0});
            if (th_hit[c]) rd_val = soc_bus_pkg::data_t'(thresh_q[c]);
            if (cl_hit[c]) rd_val = soc_bus_pkg::data_t'(claim_id[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            src_q     <= '0;
            pending_q <= '0;
            ack_q     <= 1'b0;
            for (int i = 1; i <= soc_bus_pkg::NUM_IRQ_SRC; i++) prio_q[i] <= '0;
            for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
                enable_q[c] <= '0;
                thresh_q[c] <= '0;
            end
        end else begin
            src_q     <= irq_src;
            ack_q     <= sel;
            pending_q <= (pending_q & ~clear) | rise;
            if (sel && cur_req.write) begin
                if (prio_hit && prio_ok) begin
                    prio_q[prio_idx[soc_bus_pkg::IRQ_ID_W-1:0]] <=
                        cur_req.wdata[soc_bus_pkg::PRIO_W-1:0];
                end
                for (int c = 0; c < soc_bus_pkg::NUM_CTX; c++) begin
                    if (en_hit[c]) enable_q[c] <= cur_req.wdata[soc_bus_pkg::NUM_IRQ_SRC:1];
                    if (th_hit[c]) thresh_q[c] <= cur_req.wdata[soc_bus_pkg::PRIO_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (sel) rdata_q <= rd_val;
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

/* source/ram_bank.sv */
module ram_bank (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  start,
    input  soc_bus_pkg::target_t  target,
    input  soc_bus_pkg::bus_req_t cur_req,
    output soc_bus_pkg::tgt_rsp_t rsp
);

    soc_bus_pkg::word_t mem [soc_bus_pkg::RAM_WORDS];

    logic                              sel;
    logic                              step_q;   // upper word of a double
    logic                              ack_q;
    logic [soc_bus_pkg::RAM_IDX_W-1:0] word_idx;
    logic [1:0]                        off;
    soc_bus_pkg::word_t                cur_word;
    soc_bus_pkg::word_t                shifted;
    soc_bus_pkg::word_t                wr_word;
    soc_bus_pkg::data_t                ld_val;
    soc_bus_pkg::data_t                rdata_q;

    assign sel      = start && (target == soc_bus_pkg::TGT_RAM);
    assign off      = cur_req.addr[1:0];
    assign word_idx = cur_req.addr[soc_bus_pkg::RAM_IDX_W+1:2]
                      + {{(soc_bus_pkg::RAM_IDX_W-1){1'b0}}, step_q};
    assign cur_word = mem[word_idx];
    assign shifted  = cur_word >> {off, 3'b000};

    // merge store data into its lane
    always_comb begin
        wr_word = cur_word;
        case (cur_req.ls_type)
            soc_bus_pkg::LS_B: wr_word[{off, 3'b000} +: 8] = cur_req.wdata[7:0];
            soc_bus_pkg::LS_H: wr_word[{off[1], 4'b0000} +: 16] = cur_req.wdata[15:0];
            soc_bus_pkg::LS_D: wr_word = step_q ? cur_req.wdata[63:32] : cur_req.wdata[31:0];
            default:           wr_word = cur_req.wdata[31:0];
        endcase
    end

    always_comb begin
        case (cur_req.ls_type)
            soc_bus_pkg::LS_B:  ld_val = {{56{shifted[7]}}, shifted[7:0]};
            soc_bus_pkg::LS_H:  ld_val = {{48{shifted[15]}}, shifted[15:0]};
            soc_bus_pkg::LS_W:  ld_val = {{32{shifted[31]}}, shifted};
            soc_bus_pkg::LS_BU: ld_val = {56'd0, shifted[7:0]};
            soc_bus_pkg::LS_HU: ld_val = {48'd0, shifted[15:0]};
            default:            ld_val = {32'd0, shifted};   // wu
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            step_q <= 1'b0;
            ack_q  <= 1'b0;
            if (sel && cur_req.ls_type == soc_bus_pkg::LS_D) begin
                step_q <= 1'b1;             // second word next cycle
            end else if (sel || step_q) begin
                ack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (sel || step_q) begin
            if (cur_req.write) begin
                mem[word_idx] <= wr_word;
            end else if (cur_req.ls_type == soc_bus_pkg::LS_D) begin
                if (step_q) begin
                    rdata_q[63:32] <= cur_word;
                end else begin
                    rdata_q[31:0] <= cur_word;
                end
            end else begin
                rdata_q <= ld_val;
            end
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

/* source/soc_bus_pkg.sv */
package soc_bus_pkg;

    typedef logic [31:0] addr_t;    // bus byte address
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;    // one ram entry
    typedef logic [2:0]  ls_type_t;

    // bit 2 marks unsigned loads
    localparam ls_type_t LS_B  = 3'b000;
    localparam ls_type_t LS_H  = 3'b001;
    localparam ls_type_t LS_W  = 3'b010;
    localparam ls_type_t LS_D  = 3'b011;
    localparam ls_type_t LS_BU = 3'b100;
    localparam ls_type_t LS_HU = 3'b101;
    localparam ls_type_t LS_WU = 3'b110;

    localparam addr_t RAM_BASE  = 32'h8000_0000;
    localparam int    RAM_WORDS = 2048;
    localparam int    RAM_IDX_W = 11;
    localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);

    localparam addr_t MTIMECMP_ADDR  = 32'h0200_4000;
    localparam addr_t MTIME_ADDR     = 32'h0200_BFF8;
    localparam data_t MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    localparam addr_t PLIC_BASE       = 32'h0C00_0000;
    localparam addr_t PLIC_SPAN       = 32'h0040_0000;  // whole plic window
    localparam addr_t PLIC_PENDING    = PLIC_BASE + 32'h0000_1000;
    localparam addr_t PLIC_ENABLE0    = PLIC_BASE + 32'h0000_2000;
    localparam addr_t PLIC_THRESH0    = PLIC_BASE + 32'h0020_0000;
    localparam addr_t PLIC_CLAIM0     = PLIC_THRESH0 + 32'h0000_0004;
    localparam addr_t PLIC_EN_STRIDE  = 32'h0000_0080;  // enable block per context
    localparam addr_t PLIC_CTX_STRIDE = 32'h0000_1000;  // threshold/claim per context

    localparam int NUM_IRQ_SRC = 2;   // ids 1 and 2
    localparam int NUM_CTX     = 2;   // machine and supervisor contexts
    localparam int PRIO_W      = 3;
    localparam int IRQ_ID_W    = $clog2(NUM_IRQ_SRC + 1);

    typedef logic [PRIO_W-1:0]    prio_t;
    typedef logic [IRQ_ID_W-1:0]  irq_id_t;
    typedef logic [NUM_IRQ_SRC:1] irq_vec_t;  // bit n belongs to source id n

    // target of the current access as decoded in the front end
    typedef logic [1:0] target_t;
    localparam target_t TGT_RAM   = 2'd0;
    localparam target_t TGT_TIMER = 2'd1;
    localparam target_t TGT_PLIC  = 2'd2;
    localparam target_t TGT_NONE  = 2'd3;

    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        ls_type_t ls_type;
        logic     write;
    } bus_req_t;

    typedef struct packed {
        logic  ack;     // one cycle
        data_t rdata;
    } tgt_rsp_t;

    typedef enum logic {FRONT_IDLE, FRONT_BUSY} front_state_t;

endpackage

/* source/soc_bus_top.sv */
module soc_bus_top (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  soc_bus_pkg::bus_req_t bus_req,
    input  soc_bus_pkg::irq_vec_t irq_src,
    output logic                  done,
    output soc_bus_pkg::data_t    rdata,
    output logic                  meip,
    output logic                  seip,
    output logic                  mtip
);

    logic                  start;
    logic                  complete;
    soc_bus_pkg::bus_req_t cur_req;
    soc_bus_pkg::target_t  target;
    soc_bus_pkg::tgt_rsp_t ram_rsp;
    soc_bus_pkg::tgt_rsp_t plic_rsp;
    soc_bus_pkg::tgt_rsp_t timer_rsp;

    bus_front u_front (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req_valid(req_valid),
        .bus_req  (bus_req),
        .complete (complete),
        .start    (start),
        .cur_req  (cur_req),
        .target   (target)
    );

    ram_bank u_ram (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .start   (start),
        .target  (target),
        .cur_req (cur_req),
        .rsp     (ram_rsp)
    );

    plic_regs u_plic (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .start   (start),
        .target  (target),
        .cur_req (cur_req),
        .irq_src (irq_src),
        .rsp     (plic_rsp),
        .meip    (meip),
        .seip    (seip)
    );

    machine_timer u_timer (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .start   (start),
        .target  (target),
        .cur_req (cur_req),
        .rsp     (timer_rsp),
        .mtip    (mtip)
    );

    bus_response u_response (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (start),
        .target   (target),
        .ram_rsp  (ram_rsp),
        .plic_rsp (plic_rsp),
        .timer_rsp(timer_rsp),
        .complete (complete),
        .done     (done),
        .rdata    (rdata)
    );

endmodule

/* testbench/tb_soc_bus_tests.svh */
`ifndef TB_SOC_BUS_TESTS_SVH
`define TB_SOC_BUS_TESTS_SVH

task automatic test_reset_unmapped();
    check_eq("done", 64'(done), 64'd0);
    require_irq_low("meip", meip);
    require_irq_low("seip", seip);
    require_irq_low("mtip", mtip);
    read_check("unmapped", 32'h4000_0000, soc_bus_pkg::LS_D, 64'd0);
    bus_write(soc_bus_pkg::RAM_BASE, 64'h0000_0000_CAFE_F00D, soc_bus_pkg::LS_W);
    // same low bits as ram word 0
    bus_write(32'h0000_0000, 64'h1111_2222_3333_4444, soc_bus_pkg::LS_D);
    read_check("unmapped after write", 32'h0000_0000, soc_bus_pkg::LS_D, 64'd0);
    read_check("ram word 0", soc_bus_pkg::RAM_BASE, soc_bus_pkg::LS_WU,
               64'h0000_0000_CAFE_F00D);
endtask

task automatic test_ram_round_trip();
    soc_bus_pkg::addr_t word_addr [4];
    soc_bus_pkg::word_t words [4];
    soc_bus_pkg::addr_t dbl_addr [3];
    soc_bus_pkg::data_t dbl [3];
    word_addr = '{soc_bus_pkg::RAM_BASE + 32'h10, soc_bus_pkg::RAM_BASE + 32'h104,
                  soc_bus_pkg::RAM_BASE + 32'h7F0, soc_bus_pkg::RAM_BASE + 32'h1FFC};
    dbl_addr  = '{soc_bus_pkg::RAM_BASE + 32'h200, soc_bus_pkg::RAM_BASE + 32'h408,
                  soc_bus_pkg::RAM_BASE + 32'h1FF0};
    foreach (word_addr[i]) begin
        words[i] = lcg_next();
        bus_write(word_addr[i], {32'd0, words[i]}, soc_bus_pkg::LS_W);
    end
    foreach (word_addr[i]) begin
        read_check("ram word", word_addr[i], soc_bus_pkg::LS_W,
                   {{32{words[i][31]}}, words[i]});
    end
    foreach (dbl_addr[i]) begin
        dbl[i] = {lcg_next(), lcg_next()};
        bus_write(dbl_addr[i], dbl[i], soc_bus_pkg::LS_D);
    end
    foreach (dbl_addr[i]) begin
        read_check("ram double", dbl_addr[i], soc_bus_pkg::LS_D, dbl[i]);
        read_check("double low word", dbl_addr[i], soc_bus_pkg::LS_WU, {32'd0, dbl[i][31:0]});
        read_check("double high word", dbl_addr[i] + 32'd4, soc_bus_pkg::LS_WU,
                   {32'd0, dbl[i][63:32]});
    end
endtask

task automatic test_ram_lanes();
    soc_bus_pkg::addr_t base;
    base = soc_bus_pkg::RAM_BASE + 32'h300;
    bus_write(base, 64'h0000_0000_1234_5678, soc_bus_pkg::LS_W);
    bus_write(base + 32'd1, 64'hFFFF_FFFF_FFFF_FFA5, soc_bus_pkg::LS_B);  // upper bits ignored
    read_check("byte lane 1", base, soc_bus_pkg::LS_WU, 64'h0000_0000_1234_A578);
    bus_write(base + 32'd2, 64'hFFFF_FFFF_FFFF_BEEF, soc_bus_pkg::LS_H);
    read_check("half lane 1", base, soc_bus_pkg::LS_WU, 64'h0000_0000_BEEF_A578);
    read_check("lb positive", base, soc_bus_pkg::LS_B, 64'h0000_0000_0000_0078);
    read_check("lb negative", base + 32'd1, soc_bus_pkg::LS_B, 64'hFFFF_FFFF_FFFF_FFA5);
    read_check("lbu", base + 32'd1, soc_bus_pkg::LS_BU, 64'h0000_0000_0000_00A5);
    read_check("lb top byte", base + 32'd3, soc_bus_pkg::LS_B, 64'hFFFF_FFFF_FFFF_FFBE);
    read_check("lh low half", base, soc_bus_pkg::LS_H, 64'hFFFF_FFFF_FFFF_A578);
    read_check("lh high half", base + 32'd2, soc_bus_pkg::LS_H, 64'hFFFF_FFFF_FFFF_BEEF);
    read_check("lhu", base + 32'd2, soc_bus_pkg::LS_HU, 64'h0000_0000_0000_BEEF);
    read_check("lw negative", base, soc_bus_pkg::LS_W, 64'hFFFF_FFFF_BEEF_A578);
    // second word with clear sign bits
    bus_write(base + 32'd4, 64'h0000_0000_7F3C_0102, soc_bus_pkg::LS_W);
    bus_write(base + 32'd4, 64'h0000_0000_0000_55AA, soc_bus_pkg::LS_H);
    read_check("half lane 0", base + 32'd4, soc_bus_pkg::LS_W, 64'h0000_0000_7F3C_55AA);
    read_check("lh positive", base + 32'd6, soc_bus_pkg::LS_H, 64'h0000_0000_0000_7F3C);
    read_check("lwu", base + 32'd4, soc_bus_pkg::LS_WU, 64'h0000_0000_7F3C_55AA);
    read_check("first word kept", base, soc_bus_pkg::LS_WU, 64'h0000_0000_BEEF_A578);
endtask

task automatic test_plic();
    soc_bus_pkg::addr_t claim1;
    claim1 = soc_bus_pkg::PLIC_CLAIM0 + soc_bus_pkg::PLIC_CTX_STRIDE;
    bus_write(soc_bus_pkg::PLIC_BASE + 32'd4, 64'd3, soc_bus_pkg::LS_W);
    bus_write(soc_bus_pkg::PLIC_BASE + 32'd8, 64'd5, soc_bus_pkg::LS_W);
    bus_write(soc_bus_pkg::PLIC_ENABLE0, 64'h4, soc_bus_pkg::LS_W);   // source 2 to ctx 0
    bus_write(soc_bus_pkg::PLIC_ENABLE0 + soc_bus_pkg::PLIC_EN_STRIDE, 64'h2,
              soc_bus_pkg::LS_W);                                   // source 1 to ctx 1
    bus_write(soc_bus_pkg::PLIC_THRESH0, 64'd2, soc_bus_pkg::LS_W);
    bus_write(soc_bus_pkg::PLIC_THRESH0 + soc_bus_pkg::PLIC_CTX_STRIDE, 64'd4,
              soc_bus_pkg::LS_W);
    read_check("priority 1", soc_bus_pkg::PLIC_BASE + 32'd4, soc_bus_pkg::LS_W, 64'd3);
    read_check("priority 2", soc_bus_pkg::PLIC_BASE + 32'd8, soc_bus_pkg::LS_W, 64'd5);
    read_check("enable 0", soc_bus_pkg::PLIC_ENABLE0, soc_bus_pkg::LS_W, 64'h4);
    read_check("enable 1", soc_bus_pkg::PLIC_ENABLE0 + soc_bus_pkg::PLIC_EN_STRIDE,
               soc_bus_pkg::LS_W, 64'h2);
    read_check("threshold 0", soc_bus_pkg::PLIC_THRESH0, soc_bus_pkg::LS_W, 64'd2);
    read_check("threshold 1", soc_bus_pkg::PLIC_THRESH0 + soc_bus_pkg::PLIC_CTX_STRIDE,
               soc_bus_pkg::LS_W, 64'd4);
    require_irq_low("meip", meip);
    pulse_source(2);
    check_eq("meip", 64'(meip), 64'd1);
    require_irq_low("seip", seip);
    read_check("pending", soc_bus_pkg::PLIC_PENDING, soc_bus_pkg::LS_W, 64'h4);
    read_check("claim 0", soc_bus_pkg::PLIC_CLAIM0, soc_bus_pkg::LS_W, 64'd2);
    require_irq_low("meip", meip);
    read_check("pending after claim", soc_bus_pkg::PLIC_PENDING, soc_bus_pkg::LS_W, 64'h0);
    // source 1 stays below threshold 1
    pulse_source(1);
    require_irq_low("meip", meip);
    require_irq_low("seip", seip);
    read_check("claim 1 below", claim1, soc_bus_pkg::LS_W, 64'd0);
    bus_write(soc_bus_pkg::PLIC_BASE + 32'd4, 64'd4, soc_bus_pkg::LS_W);  // equal now
    require_irq_low("seip", seip);
    read_check("claim 1 at", claim1, soc_bus_pkg::LS_W, 64'd0);
    read_check("pending source 1", soc_bus_pkg::PLIC_PENDING, soc_bus_pkg::LS_W, 64'h2);
    bus_write(soc_bus_pkg::PLIC_BASE + 32'd4, 64'd5, soc_bus_pkg::LS_W);
    check_eq("seip", 64'(seip), 64'd1);
    read_check("claim 1 above", claim1, soc_bus_pkg::LS_W, 64'd1);
    require_irq_low("seip", seip);
endtask

task automatic test_timer();
    soc_bus_pkg::data_t t0;
    soc_bus_pkg::data_t t1;
    bus_read(soc_bus_pkg::MTIME_ADDR, soc_bus_pkg::LS_D, t0);
    bus_read(soc_bus_pkg::MTIME_ADDR, soc_bus_pkg::LS_D, t1);
    check_eq("mtime increasing", 64'(t1 > t0), 64'd1);
    read_check("mtimecmp reset", soc_bus_pkg::MTIMECMP_ADDR, soc_bus_pkg::LS_D,
               soc_bus_pkg::MTIMECMP_RESET);
    bus_write(soc_bus_pkg::MTIMECMP_ADDR, t1 + 64'd200, soc_bus_pkg::LS_D);
    require_irq_low("mtip", mtip);
    read_check("mtimecmp", soc_bus_pkg::MTIMECMP_ADDR, soc_bus_pkg::LS_D, t1 + 64'd200);
    repeat (300) @(posedge CLOCK_50);
    #1;
    check_eq("mtip", 64'(mtip), 64'd1);
    bus_write(soc_bus_pkg::MTIMECMP_ADDR, 64'hFFFF_FFFF_FFFF_FFFF, soc_bus_pkg::LS_D);
    require_irq_low("mtip", mtip);
endtask

`endif

/* testbench/tb_soc_bus.sv */
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS    = 5;
    localparam int TEST_SPAN_NS = 2000;  // time budget per test
    localparam int DONE_LIMIT   = 20;    // cycles to wait for done

    logic                  CLOCK_50;
    logic                  KEY0;
    logic                  req_valid;
    soc_bus_pkg::bus_req_t bus_req;
    soc_bus_pkg::irq_vec_t irq_src;
    logic                  done;
    soc_bus_pkg::data_t    rdata;
    logic                  meip;
    logic                  seip;
    logic                  mtip;
    logic [31:0]           lcg_state;

    soc_bus_top uut (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req_valid(req_valid),
        .bus_req  (bus_req),
        .irq_src  (irq_src),
        .done     (done),
        .rdata    (rdata),
        .meip     (meip),
        .seip     (seip),
        .mtip     (mtip)
    );

    initial CLOCK_50 = 1'b0;
    always #5 CLOCK_50 = ~CLOCK_50;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %0d ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
            fail_stop("a checked value did not match, stopping the run");
        end
    endtask

    task automatic require_irq_low(input string line_name, input logic level);
        if (level !== 1'b0) begin
            fail_stop({line_name, " is high although no interrupt is expected there"});
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // one transaction with the request held until done
    task automatic bus_access(input soc_bus_pkg::addr_t a, input soc_bus_pkg::data_t wd,
                              input soc_bus_pkg::ls_type_t ls, input logic wr,
                              output soc_bus_pkg::data_t rd);
        int cycles;
        @(posedge CLOCK_50);
        #1;
        bus_req.addr    = a;
        bus_req.wdata   = wd;
        bus_req.ls_type = ls;
        bus_req.write   = wr;
        req_valid       = 1'b1;
        cycles          = 0;
        do begin
            @(posedge CLOCK_50);
            #1;
            cycles++;
            if (!done && cycles >= DONE_LIMIT) begin
                fail_stop($sformatf("no done within %0d cycles for address 0x%h",
                                    DONE_LIMIT, a));
            end
        end while (!done);
        rd        = rdata;
        req_valid = 1'b0;   // released during the done cycle
    endtask

    task automatic bus_write(input soc_bus_pkg::addr_t a, input soc_bus_pkg::data_t wd,
                             input soc_bus_pkg::ls_type_t ls);
        soc_bus_pkg::data_t unused;
        bus_access(a, wd, ls, 1'b1, unused);
    endtask

    task automatic bus_read(input soc_bus_pkg::addr_t a, input soc_bus_pkg::ls_type_t ls,
                            output soc_bus_pkg::data_t rd);
        bus_access(a, 64'd0, ls, 1'b0, rd);
    endtask

    task automatic read_check(input string name, input soc_bus_pkg::addr_t a,
                              input soc_bus_pkg::ls_type_t ls,
                              input soc_bus_pkg::data_t expected);
        soc_bus_pkg::data_t val;
        bus_read(a, ls, val);
        check_eq($sformatf("%s rdata @0x%h", name, a), val, expected);
    endtask

    // single cycle high on one source
    task automatic pulse_source(input int id);
        @(posedge CLOCK_50);
        #1;
        irq_src[id] = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_src[id] = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        #1;
    endtask

    `include "tb_soc_bus_tests.svh"

    initial begin
        #(NUM_TESTS * TEST_SPAN_NS);
        fail_stop("watchdog expired before the test sequence finished");
    end

    initial begin
        lcg_state   = 32'd87762;
        KEY0        = 1'b0;
        req_valid   = 1'b0;
        bus_req     = '0;
        irq_src     = '0;
        repeat (8) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        test_reset_unmapped();
        test_ram_round_trip();
        test_ram_lanes();
        test_plic();
        test_timer();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
